// ==== Makefile ====
SIM_LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run tb_pipe_trace, check $(SIM_LOG)"
	@echo "  clean  remove obj_dir and $(SIM_LOG)"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f project.f --top-module tb_pipe_trace -o sim_tb
	-./obj_dir/sim_tb > $(SIM_LOG) 2>&1
	@cat $(SIM_LOG)
	@if grep -q "tests failed" $(SIM_LOG); then exit 1; fi
	@# A run that stopped early prints neither message
	@grep -q "all tests passed" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)

// ==== back_stages.sv ====
`timescale 1ns/1ps

module back_stages import pipe_trace_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  trace_rec_t front_rec,
    input  logic       front_out_valid,
    output logic       exec_valid,
    output logic       mem_valid,
    output logic       wb_valid,
    output logic       retire_valid,
    output instr_t     retire_instr,
    output cycle_t     retire_issue_cycle,
    output dwell_t     retire_dwell
);

    trace_rec_t exec_rec;
    trace_rec_t mem_rec;
    trace_rec_t wb_rec;

    // The back end never holds
    // A missing record enters execute as a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            exec_valid <= 1'b0;
            mem_valid  <= 1'b0;
            wb_valid   <= 1'b0;
        end else begin
            exec_valid <= front_out_valid;
            mem_valid  <= exec_valid;
            wb_valid   <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        exec_rec <= front_rec;
        mem_rec  <= exec_rec;
        wb_rec   <= mem_rec;
    end

    // Writeback slot is the retire record
    assign retire_valid       = wb_valid;
    assign retire_instr       = wb_rec.instr;
    assign retire_issue_cycle = wb_rec.issue_cycle;
    assign retire_dwell       = wb_rec.dwell;

    dwell_cap_a: assert property (
        @(posedge clk) disable iff (rst)
        retire_valid |-> (retire_dwell <= DWELL_MAX)
    );

endmodule

// ==== cycle_timer.sv ====
`timescale 1ns/1ps

module cycle_timer import pipe_trace_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   stall,
    output cycle_t cycle_count,
    output cycle_t stall_total
);

    // Set once the cycle counter has gone round
    logic wrapped;

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_count <= '0;
            stall_total <= '0;
            wrapped     <= 1'b0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
            if (stall) begin
                stall_total <= stall_total + 1'b1;
            end
            if (cycle_count == '1) begin
                wrapped <= 1'b1;
            end
        end
    end

    // Stalled cycles are a subset of all cycles until the wrap
    stall_le_cycles_a: assert property (
        @(posedge clk) disable iff (rst)
        !wrapped |-> (stall_total <= cycle_count)
    );

endmodule

// ==== front_stages.sv ====
`timescale 1ns/1ps

module front_stages import pipe_trace_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       stall,
    input  logic       issue_valid,
    input  instr_t     issue_instr,
    input  cycle_t     cycle_count,
    output logic       fetch_valid,
    output logic       decode_valid,
    output trace_rec_t front_rec,
    output logic       front_out_valid
);

    trace_rec_t fetch_rec;
    trace_rec_t decode_rec;

    // Raise a dwell count by one, holding at the limit
    function automatic dwell_t dwell_step(input dwell_t d);
        if (d >= DWELL_MAX) begin
            return DWELL_MAX;
        end
        return d + 1'b1;
    endfunction

    // Valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_valid  <= 1'b0;
            decode_valid <= 1'b0;
        end else if (!stall) begin
            fetch_valid  <= issue_valid;
            decode_valid <= fetch_valid;
        end
    end

    // Records, held in place while stalled
    always_ff @(posedge clk) begin
        if (stall) begin
            if (fetch_valid) begin
                fetch_rec.dwell <= dwell_step(fetch_rec.dwell);
            end
            if (decode_valid) begin
                decode_rec.dwell <= dwell_step(decode_rec.dwell);
            end
        end else begin
            decode_rec <= fetch_rec;
            if (issue_valid) begin
                // Stamp with the count seen before this edge
                fetch_rec.instr       <= issue_instr;
                fetch_rec.issue_cycle <= cycle_count;
                fetch_rec.dwell       <= '0;
            end
        end
    end

    assign front_rec       = decode_rec;
    assign front_out_valid = decode_valid && !stall;

    fetch_hold_a: assert property (
        @(posedge clk) disable iff (rst)
        (stall && fetch_valid) |=> (fetch_valid && fetch_rec.instr == $past(fetch_rec.instr))
    );

    decode_hold_a: assert property (
        @(posedge clk) disable iff (rst)
        (stall && decode_valid) |=> (decode_valid && decode_rec.instr == $past(decode_rec.instr))
    );

endmodule

// ==== pipe_trace_pkg.sv ====
package pipe_trace_pkg;

    // Pipeline geometry
    localparam int STAGE_COUNT = 5;
    localparam int OCC_W       = $clog2(STAGE_COUNT + 1);

    // Field widths of the trace record
    localparam int INSTR_W = 32;
    localparam int CYCLE_W = 16;
    localparam int DWELL_W = 3;

    typedef logic [INSTR_W-1:0] instr_t;

    // Cycle stamps wrap at 2**CYCLE_W
    typedef logic [CYCLE_W-1:0] cycle_t;

    // Stalled cycles spent in fetch or decode
    typedef logic [DWELL_W-1:0] dwell_t;

    typedef logic [OCC_W-1:0] occ_t;

    // Dwell saturates here
    localparam dwell_t DWELL_MAX = dwell_t'(7);

    // Record carried by each instruction down the pipe
    typedef struct packed {
        instr_t instr;
        cycle_t issue_cycle;
        dwell_t dwell;
    } trace_rec_t;

    // Pipeline status seen from outside
    typedef enum logic [1:0] {
        PIPE_IDLE  = 2'd0,
        PIPE_RUN   = 2'd1,
        PIPE_STALL = 2'd2
    } pipe_state_t;

endpackage

// ==== pipe_trace_top.sv ====
`timescale 1ns/1ps

module pipe_trace_top import pipe_trace_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        issue_valid,
    input  instr_t      issue_instr,
    input  logic        stall,
    output logic        retire_valid,
    output instr_t      retire_instr,
    output cycle_t      retire_issue_cycle,
    output dwell_t      retire_dwell,
    output cycle_t      cycle_count,
    output cycle_t      stall_total,
    output pipe_state_t pipe_state,
    output occ_t        occupancy
);

    logic       fetch_valid;
    logic       decode_valid;
    logic       exec_valid;
    logic       mem_valid;
    logic       wb_valid;
    trace_rec_t front_rec;
    logic       front_out_valid;

    stage_seq_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .issue_valid  (issue_valid),
        .fetch_valid  (fetch_valid),
        .decode_valid (decode_valid),
        .exec_valid   (exec_valid),
        .mem_valid    (mem_valid),
        .wb_valid     (wb_valid),
        .pipe_state   (pipe_state),
        .occupancy    (occupancy)
    );

    cycle_timer u_timer (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .cycle_count (cycle_count),
        .stall_total (stall_total)
    );

    // Fetch and decode, stamped from the running cycle count
    front_stages u_front (
        .clk             (clk),
        .rst             (rst),
        .stall           (stall),
        .issue_valid     (issue_valid),
        .issue_instr     (issue_instr),
        .cycle_count     (cycle_count),
        .fetch_valid     (fetch_valid),
        .decode_valid    (decode_valid),
        .front_rec       (front_rec),
        .front_out_valid (front_out_valid)
    );

    back_stages u_back (
        .clk                (clk),
        .rst                (rst),
        .front_rec          (front_rec),
        .front_out_valid    (front_out_valid),
        .exec_valid         (exec_valid),
        .mem_valid          (mem_valid),
        .wb_valid           (wb_valid),
        .retire_valid       (retire_valid),
        .retire_instr       (retire_instr),
        .retire_issue_cycle (retire_issue_cycle),
        .retire_dwell       (retire_dwell)
    );

endmodule

// ==== project.f ====
pipe_trace_pkg.sv
stage_seq_ctrl.sv
cycle_timer.sv
front_stages.sv
back_stages.sv
pipe_trace_top.sv
tb_pipe_trace.sv

// ==== stage_seq_ctrl.sv ====
`timescale 1ns/1ps

module stage_seq_ctrl import pipe_trace_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  logic        issue_valid,
    input  logic        fetch_valid,
    input  logic        decode_valid,
    input  logic        exec_valid,
    input  logic        mem_valid,
    input  logic        wb_valid,
    output pipe_state_t pipe_state,
    output occ_t        occupancy
);

    logic        next_fetch;
    logic        next_decode;
    logic        next_exec;
    logic        next_mem;
    logic        next_wb;
    occ_t        next_occ;
    pipe_state_t next_state;

    // Slot valid bits as they will stand after this edge
    always_comb begin
        next_fetch  = stall ? fetch_valid : issue_valid;
        next_decode = stall ? decode_valid : fetch_valid;
        next_exec   = decode_valid && !stall;
        next_mem    = exec_valid;
        next_wb     = mem_valid;
    end

    assign next_occ = occ_t'(next_fetch) + occ_t'(next_decode) + occ_t'(next_exec)
                    + occ_t'(next_mem) + occ_t'(next_wb);

    // A stall only counts as such while the front holds something
    always_comb begin
        if (next_occ == '0) begin
            next_state = PIPE_IDLE;
        end else if (stall && (next_fetch || next_decode)) begin
            next_state = PIPE_STALL;
        end else begin
            next_state = PIPE_RUN;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pipe_state <= PIPE_IDLE;
            occupancy  <= '0;
        end else begin
            pipe_state <= next_state;
            occupancy  <= next_occ;
        end
    end

    occ_bound_a: assert property (
        @(posedge clk) disable iff (rst)
        occupancy <= occ_t'(STAGE_COUNT)
    );

    // Prediction must agree with the slot registers in the stage modules
    idle_empty_a: assert property (
        @(posedge clk) disable iff (rst)
        (pipe_state == PIPE_IDLE) |->
            !(fetch_valid || decode_valid || exec_valid || mem_valid || wb_valid)
    );

endmodule

// ==== tb_pipe_trace.sv ====
`timescale 1ns/1ps

module tb_pipe_trace import pipe_trace_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int FILL_CYCLES  = 30;
    localparam int RAND_CYCLES  = 150;
    localparam int LONG_STALL   = 10;
    localparam int DRAIN_CYCLES = 12;
    localparam int TOTAL_CYCLES = RESET_CYCLES + FILL_CYCLES + RAND_CYCLES + 2
                                + LONG_STALL + DRAIN_CYCLES + 1;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic        clk;
    logic        rst;
    logic        issue_valid;
    instr_t      issue_instr;
    logic        stall;
    logic        retire_valid;
    instr_t      retire_instr;
    cycle_t      retire_issue_cycle;
    dwell_t      retire_dwell;
    cycle_t      cycle_count;
    cycle_t      stall_total;
    pipe_state_t pipe_state;
    occ_t        occupancy;

    // Model slots in pipeline order, fetch at index 0 and writeback at index 4
    logic        m_valid [STAGE_COUNT];
    trace_rec_t  m_rec [STAGE_COUNT];
    int          m_stalls [STAGE_COUNT];
    cycle_t      m_cycle;
    cycle_t      m_stall_total;
    logic [31:0] lfsr_state = 32'h070930e7;
    int          accepted = 0;
    int          retired = 0;
    int          saturated = 0;

    pipe_trace_top dut0 (
        .clk                (clk),
        .rst                (rst),
        .issue_valid        (issue_valid),
        .issue_instr        (issue_instr),
        .stall              (stall),
        .retire_valid       (retire_valid),
        .retire_instr       (retire_instr),
        .retire_issue_cycle (retire_issue_cycle),
        .retire_dwell       (retire_dwell),
        .cycle_count        (cycle_count),
        .stall_total        (stall_total),
        .pipe_state         (pipe_state),
        .occupancy          (occupancy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Advance the reference pipeline by one rising edge
    function void step_reference(input logic r, input logic s, input logic iv, input instr_t ins);
        if (r) begin
            for (int i = 0; i < STAGE_COUNT; i++) begin
                m_valid[i]  = 1'b0;
                m_stalls[i] = 0;
            end
            m_cycle       = '0;
            m_stall_total = '0;
        end else begin
            // Memory and writeback shift regardless of stall
            for (int i = STAGE_COUNT - 1; i >= 3; i--) begin
                m_valid[i]  = m_valid[i-1];
                m_rec[i]    = m_rec[i-1];
                m_stalls[i] = m_stalls[i-1];
            end
            if (s) begin
                m_valid[2] = 1'b0;
                for (int i = 0; i < 2; i++) begin
                    if (m_valid[i]) begin
                        m_stalls[i]++;
                        if (m_rec[i].dwell != DWELL_MAX) begin
                            m_rec[i].dwell = m_rec[i].dwell + 1'b1;
                        end
                    end
                end
                m_stall_total = m_stall_total + 1'b1;
            end else begin
                for (int i = 2; i >= 1; i--) begin
                    m_valid[i]  = m_valid[i-1];
                    m_rec[i]    = m_rec[i-1];
                    m_stalls[i] = m_stalls[i-1];
                end
                m_valid[0] = iv;
                if (iv) begin
                    m_rec[0]    = '{instr: ins, issue_cycle: m_cycle, dwell: '0};
                    m_stalls[0] = 0;
                    accepted++;
                end
            end
            m_cycle = m_cycle + 1'b1;
        end
    endfunction

    function occ_t count_valid_slots();
        int n;
        n = 0;
        for (int i = 0; i < STAGE_COUNT; i++) begin
            n += int'(m_valid[i]);
        end
        return occ_t'(n);
    endfunction

    function pipe_state_t expected_state(input logic s);
        if (count_valid_slots() == '0) begin
            return PIPE_IDLE;
        end else if (s && (m_valid[0] || m_valid[1])) begin
            return PIPE_STALL;
        end
        return PIPE_RUN;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_rec(input string name, input trace_rec_t got, input trace_rec_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_cycle(input string name, input cycle_t got, input cycle_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_state(input string name, input pipe_state_t got, input pipe_state_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s got %0d expected %s",
                                $time, name, got, exp.name()));
        end
    endtask

    task automatic check_occ(input string name, input occ_t got, input occ_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // Inputs are stable here since they only change on the falling edge
    initial begin
        trace_rec_t got_rec;
        forever begin
            @(posedge clk);
            #1;
            step_reference(rst, stall, issue_valid, issue_instr);
            check_bit("retire_valid", retire_valid, m_valid[4]);
            if (m_valid[4]) begin
                got_rec.instr       = retire_instr;
                got_rec.issue_cycle = retire_issue_cycle;
                got_rec.dwell       = retire_dwell;
                check_rec("retire record", got_rec, m_rec[4]);
                check_cycle("retire latency", cycle_count - retire_issue_cycle,
                            cycle_t'(5 + m_stalls[4]));
                retired++;
                if (retire_dwell == DWELL_MAX) begin
                    saturated++;
                end
            end
            check_cycle("cycle_count", cycle_count, m_cycle);
            check_cycle("stall_total", stall_total, m_stall_total);
            check_occ("occupancy", occupancy, count_valid_slots());
            check_state("pipe_state", pipe_state, expected_state(stall));
        end
    end

    task automatic drive_cycle(input logic iv, input logic st, input instr_t ins);
        @(negedge clk);
        issue_valid = iv;
        stall       = st;
        issue_instr = ins;
    endtask

    initial begin
        rst         = 1'b1;
        issue_valid = 1'b0;
        stall       = 1'b0;
        issue_instr = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // Fill with no stall and issue density three in four
        repeat (FILL_CYCLES) drive_cycle(rand_bits(2) != 0, 1'b0, rand_bits(32));

        // Stall with density one in four
        repeat (RAND_CYCLES) drive_cycle(rand_bits(2) != 0, rand_bits(2) == 3, rand_bits(32));

        // Long stall with both front slots full
        // Offers keep coming during the stall and are dropped
        drive_cycle(1'b1, 1'b0, rand_bits(32));
        drive_cycle(1'b1, 1'b0, rand_bits(32));
        repeat (LONG_STALL) drive_cycle(1'b1, 1'b1, rand_bits(32));

        repeat (DRAIN_CYCLES) drive_cycle(1'b0, 1'b0, '0);
        @(posedge clk);
        #2;

        check_state("pipe_state after drain", pipe_state, PIPE_IDLE);
        if (saturated == 0) begin
            abort_run("No retired record reached the dwell limit");
        end else if (retired != accepted) begin
            abort_run($sformatf("Accepted %0d instructions but %0d retired", accepted, retired));
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

    initial begin
        #(longint'(TOTAL_CYCLES + 20) * CLK_PERIOD);
        abort_run("Watchdog expired before the stimulus finished");
    end

endmodule
